//--- hw/cpuPkg.sv
package cpuPkg;

	localparam int dataW = 16; // data path and address width
	localparam int regIdW = 4; // 16 architectural registers

	typedef logic [dataW-1:0] wordT;
	typedef logic [dataW-1:0] addrT; // byte address, pc steps by 2
	typedef logic [regIdW-1:0] regIdT;

	// saturation limits for add and sub
	localparam wordT satMax = 16'h7fff;
	localparam wordT satMin = 16'h8000;

	// codes 3, 7 and 14 are free and decode as no-ops
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		XOR = 4'd2,
		SLL = 4'd4,
		SRA = 4'd5,
		ROR = 4'd6,
		LW  = 4'd8,
		SW  = 4'd9,
		LLB = 4'd10,
		LHB = 4'd11,
		B   = 4'd12,
		BR  = 4'd13,
		HLT = 4'd15
	} opT;

	// branch condition, instr[11:9]
	typedef enum logic [2:0] {
		NE, // z clear
		EQ, // z set
		GT, // z and n clear
		LT, // n set
		GE, // z set or n clear
		LE, // z or n set
		OV, // v set
		UN  // always
	} condT;

	typedef enum logic [1:0] {fwdRf, fwdMem, fwdWb} fwdSelT;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flagsT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg; // wb takes load data
		logic aluSrcImm; // alu b from immediate
		logic isBranch; // any B or BR
		logic isBranchReg; // BR only, target from rs
		logic isHalt;
		flagsT flagWe; // per flag write enable
	} ctrlT;

	typedef struct packed {
		wordT instr;
		addrT pcPlus2;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		opT op;
		wordT opA; // rs value
		wordT opB; // rt value, rd for SW and LLB/LHB
		wordT imm;
		regIdT rsId;
		regIdT rtId;
		regIdT rdId;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		wordT aluResult; // also the data address
		wordT storeData;
		regIdT rdId;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic isHalt;
		wordT aluResult;
		wordT loadData;
		regIdT rdId;
	} memWbT;

	// request seen on the data memory port
	typedef struct packed {
		addrT addr;
		wordT wdata;
		logic we;
		logic re;
	} dmemReqT;

endpackage

//--- hw/pipeReg.sv
`timescale 1ns/10ps

// one stage register, shared by all four pipeline boundaries
module pipeReg import cpuPkg::*; #(
	parameter type payloadT = idExT
) (
	input  logic    clk,
	input  logic    arstN,
	input  logic    en, // low holds the stage
	input  logic    flush, // load a bubble
	input  payloadT d,
	output payloadT q
);

	// all-zero payload is a bubble, ctrl bits zero
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end else if (flush) begin
			q <= '0; // wins over a hold
		end else if (en) begin
			q <= d;
		end
	end

endmodule

//--- hw/decodeCtrl.sv
`timescale 1ns/10ps

module decodeCtrl import cpuPkg::*; (
	input  wordT  instr,
	output ctrlT  ctrl,
	output regIdT rsId,
	output regIdT rtId,
	output regIdT rdId,
	output wordT  imm
);

	opT op;
	wordT memOff; // signed word offset, in bytes
	wordT brOff; // signed 9 bit word offset, in bytes
	wordT byteImm; // LLB/LHB constant

	assign op = opT'(instr[15:12]);
	assign memOff = {{11{instr[3]}}, instr[3:0], 1'b0};
	assign brOff = {{6{instr[8]}}, instr[8:0], 1'b0};
	assign byteImm = {{8{instr[7]}}, instr[7:0]};

	// unused ids stay at r0 so hazards never see them
	always_comb begin
		ctrl = '0;
		rsId = '0;
		rtId = '0;
		rdId = '0;
		imm = '0;
		// the all-zero word is the bubble left by a flush, treat as no-op
		if (instr != '0) begin
			case (op)
				ADD, SUB: begin
					ctrl.regWrite = 1'b1;
					ctrl.flagWe = '1; // z, v and n
					rsId = instr[7:4];
					rtId = instr[3:0];
					rdId = instr[11:8];
				end
				XOR: begin
					ctrl.regWrite = 1'b1;
					ctrl.flagWe.z = 1'b1;
					rsId = instr[7:4];
					rtId = instr[3:0];
					rdId = instr[11:8];
				end
				SLL, SRA, ROR: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.flagWe.z = 1'b1;
					rsId = instr[7:4];
					rdId = instr[11:8];
					imm = {12'h000, instr[3:0]}; // shift amount
				end
				LW: begin
					ctrl.regWrite = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.memToReg = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					rsId = instr[7:4];
					rdId = instr[11:8];
					imm = memOff;
				end
				SW: begin
					ctrl.memWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					rsId = instr[7:4];
					rtId = instr[11:8]; // data reg on read port 2
					imm = memOff;
				end
				LLB, LHB: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					rtId = instr[11:8]; // old rd value, one byte kept
					rdId = instr[11:8];
					imm = byteImm;
				end
				B: begin
					ctrl.isBranch = 1'b1;
					imm = brOff;
				end
				BR: begin
					ctrl.isBranch = 1'b1;
					ctrl.isBranchReg = 1'b1;
					rsId = instr[7:4]; // target register
				end
				HLT: ctrl.isHalt = 1'b1;
				default: ; // free opcodes, no-op
			endcase
		end
	end

endmodule

//--- hw/regFile.sv
`timescale 1ns/10ps

module regFile import cpuPkg::*; (
	input  logic  clk,
	input  logic  arstN,
	input  regIdT rdAddr1,
	input  regIdT rdAddr2,
	input  regIdT wrAddr,
	input  logic  wrEn,
	input  wordT  wrData,
	output wordT  rdData1,
	output wordT  rdData2
);

	wordT regs [2**regIdW];
	logic wrLive; // a real write this cycle

	assign wrLive = wrEn && (wrAddr != '0); // r0 never written

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**regIdW; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-through, decode sees the value wb writes this cycle
	assign rdData1 = (wrLive && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];
	assign rdData2 = (wrLive && wrAddr == rdAddr2) ? wrData : regs[rdAddr2];

endmodule

//--- hw/aluUnit.sv
`timescale 1ns/10ps

module aluUnit import cpuPkg::*; (
	input  opT    op,
	input  wordT  a,
	input  wordT  b,
	output wordT  result,
	output flagsT flags
);

	logic isSub;
	wordT bOp; // b, inverted for sub
	wordT sum;
	logic ovf;
	logic [2*dataW-1:0] rot; // a twice, for the rotate

	assign isSub = (op == SUB);
	assign bOp = isSub ? ~b : b;
	assign sum = a + bOp + {15'h0000, isSub}; // two's complement sub
	// same operand signs, result sign flipped
	assign ovf = (a[dataW-1] == bOp[dataW-1]) && (sum[dataW-1] != a[dataW-1]);
	assign rot = {a, a} >> b[3:0];

	always_comb begin
		case (op)
			ADD, SUB: begin
				if (ovf) begin
					result = a[dataW-1] ? satMin : satMax; // clamp toward a's sign
				end else begin
					result = sum;
				end
			end
			XOR: result = a ^ b;
			SLL: result = a << b[3:0];
			SRA: result = wordT'($signed(a) >>> b[3:0]);
			ROR: result = rot[dataW-1:0];
			LW, SW: result = a + b; // base plus byte offset
			LLB: result = {a[15:8], b[7:0]};
			LHB: result = {b[7:0], a[7:0]};
			default: result = '0; // branches, halt, no-ops
		endcase
	end

	// enables in ctrl decide which flags land
	assign flags.z = (result == '0);
	assign flags.v = ovf && (op == ADD || op == SUB);
	assign flags.n = result[dataW-1];

endmodule

//--- hw/flagBranch.sv
`timescale 1ns/10ps

module flagBranch import cpuPkg::*; (
	input  logic  clk,
	input  logic  arstN,
	input  flagsT flagsIn, // from alu, execute stage
	input  flagsT flagWe, // from the execute instr
	input  logic  isBranch, // decode instr is a branch, not stalled
	input  condT  cond,
	output logic  taken
);

	flagsT flags;
	logic condMet;

	// each flag keeps its value unless its own enable is set
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else begin
			if (flagWe.z) flags.z <= flagsIn.z;
			if (flagWe.v) flags.v <= flagsIn.v;
			if (flagWe.n) flags.n <= flagsIn.n;
		end
	end

	always_comb begin
		case (cond)
			NE: condMet = !flags.z;
			EQ: condMet = flags.z;
			GT: condMet = !flags.z && !flags.n;
			LT: condMet = flags.n;
			GE: condMet = flags.z || !flags.n;
			LE: condMet = flags.z || flags.n;
			OV: condMet = flags.v;
			default: condMet = 1'b1; // UN
		endcase
	end

	assign taken = isBranch && condMet;

endmodule

//--- hw/hazardFwd.sv
`timescale 1ns/10ps

module hazardFwd import cpuPkg::*; (
	input  regIdT   idRs,
	input  regIdT   idRt,
	input  ctrlT    idCtrl,
	input  idExT    exPipe,
	input  exMemT   memPipe,
	input  memWbT   wbPipe,
	output fwdSelT  fwdA,
	output fwdSelT  fwdB,
	output logic    stall
);

	logic loadUse;
	logic flagWait;
	logic regWait;
	logic exWritesRs; // execute instr produces the BR register
	logic memWritesRs;

	// mem stage is newer than wb, so it is checked first
	function automatic fwdSelT pickSrc(regIdT id);
		if (id == '0) begin
			return fwdRf; // r0 is always zero
		end else if (memPipe.ctrl.regWrite && memPipe.rdId == id) begin
			return fwdMem;
		end else if (wbPipe.regWrite && wbPipe.rdId == id) begin
			return fwdWb;
		end
		return fwdRf;
	endfunction

	assign fwdA = pickSrc(exPipe.rsId);
	assign fwdB = pickSrc(exPipe.rtId); // also covers SW data

	// load in execute, its result is needed by decode
	assign loadUse = exPipe.ctrl.memRead && (exPipe.rdId != '0) &&
		(exPipe.rdId == idRs || exPipe.rdId == idRt);

	// flags not yet written when the producer is still in execute
	assign flagWait = idCtrl.isBranch && (|exPipe.ctrl.flagWe);

	assign exWritesRs = exPipe.ctrl.regWrite && (exPipe.rdId == idRs);
	assign memWritesRs = memPipe.ctrl.regWrite && (memPipe.rdId == idRs);
	// BR reads its target in decode, wb value comes through the rf bypass
	assign regWait = idCtrl.isBranchReg && (idRs != '0) && (exWritesRs || memWritesRs);

	assign stall = loadUse || flagWait || regWait;

endmodule

//--- hw/cpu.sv
`timescale 1ns/10ps

module cpu import cpuPkg::*; (
	input  logic    clk,
	input  logic    arstN,
	output addrT    imemAddr,
	input  wordT    imemData,
	output dmemReqT dmemReq,
	input  wordT    dmemRdata,
	output addrT    pc,
	output logic    hlt
);

	addrT pcReg;
	addrT pcPlus2;
	addrT pcNext;
	addrT brTarget;
	logic stall;
	logic taken;

	ifIdT ifIdD, ifId;
	idExT idExD, idEx;
	exMemT exMemD, exMem;
	memWbT memWbD, memWb;

	ctrlT idCtrl;
	regIdT rsId, rtId, rdId;
	wordT idImm;
	wordT rfA, rfB;

	fwdSelT fwdA, fwdB;
	wordT opAFwd, opBFwd;
	wordT aluA, aluB;
	wordT aluResult;
	flagsT aluFlags;
	wordT wbValue;

	// fetch
	assign pcPlus2 = pcReg + 16'd2;
	assign imemAddr = pcReg;
	assign pc = pcReg;

	// stall first, a taken branch overrides a fetched HLT in its shadow
	always_comb begin
		if (stall) begin
			pcNext = pcReg;
		end else if (taken) begin
			pcNext = brTarget;
		end else if (opT'(imemData[15:12]) == HLT) begin
			pcNext = pcReg; // park on the HLT
		end else begin
			pcNext = pcPlus2;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) pcReg <= '0;
		else pcReg <= pcNext;
	end

	assign ifIdD = '{instr: imemData, pcPlus2: pcPlus2};

	pipeReg #(.payloadT(ifIdT)) ifIdReg (
		.clk, .arstN,
		.en(!stall),
		.flush(taken), // drop the slot behind a taken branch
		.d(ifIdD),
		.q(ifId)
	);

	// decode
	decodeCtrl dec (
		.instr(ifId.instr),
		.ctrl(idCtrl),
		.rsId, .rtId, .rdId,
		.imm(idImm)
	);

	regFile rf (
		.clk, .arstN,
		.rdAddr1(rsId),
		.rdAddr2(rtId),
		.wrAddr(memWb.rdId),
		.wrEn(memWb.regWrite),
		.wrData(wbValue),
		.rdData1(rfA),
		.rdData2(rfB)
	);

	assign brTarget = idCtrl.isBranchReg ? rfA : ifId.pcPlus2 + idImm;

	hazardFwd haz (
		.idRs(rsId),
		.idRt(rtId),
		.idCtrl,
		.exPipe(idEx),
		.memPipe(exMem),
		.wbPipe(memWb),
		.fwdA, .fwdB,
		.stall
	);

	// flags of the execute instr, branch resolved in decode
	flagBranch fb (
		.clk, .arstN,
		.flagsIn(aluFlags),
		.flagWe(idEx.ctrl.flagWe),
		.isBranch(idCtrl.isBranch && !stall), // stalled branch retries next cycle
		.cond(condT'(ifId.instr[11:9])),
		.taken
	);

	assign idExD = '{
		ctrl: idCtrl,
		op: opT'(ifId.instr[15:12]),
		opA: rfA,
		opB: rfB,
		imm: idImm,
		rsId: rsId,
		rtId: rtId,
		rdId: rdId
	};

	pipeReg #(.payloadT(idExT)) idExReg (
		.clk, .arstN,
		.en(1'b1),
		.flush(stall), // bubble into execute
		.d(idExD),
		.q(idEx)
	);

	// execute
	always_comb begin
		case (fwdA)
			fwdMem: opAFwd = exMem.aluResult;
			fwdWb: opAFwd = wbValue;
			default: opAFwd = idEx.opA;
		endcase
		case (fwdB)
			fwdMem: opBFwd = exMem.aluResult;
			fwdWb: opBFwd = wbValue;
			default: opBFwd = idEx.opB;
		endcase
	end

	// byte loads patch the old rd, which arrives on the b side
	assign aluA = (idEx.op == LLB || idEx.op == LHB) ? opBFwd : opAFwd;
	assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opBFwd;

	aluUnit alu (
		.op(idEx.op),
		.a(aluA),
		.b(aluB),
		.result(aluResult),
		.flags(aluFlags)
	);

	assign exMemD = '{
		ctrl: idEx.ctrl,
		aluResult: aluResult,
		storeData: opBFwd, // forwarded like any operand
		rdId: idEx.rdId
	};

	pipeReg #(.payloadT(exMemT)) exMemReg (
		.clk, .arstN,
		.en(1'b1),
		.flush(1'b0),
		.d(exMemD),
		.q(exMem)
	);

	// memory, combinational port, read data same cycle
	assign dmemReq = '{
		addr: exMem.aluResult,
		wdata: exMem.storeData,
		we: exMem.ctrl.memWrite,
		re: exMem.ctrl.memRead
	};

	assign memWbD = '{
		regWrite: exMem.ctrl.regWrite,
		memToReg: exMem.ctrl.memToReg,
		isHalt: exMem.ctrl.isHalt,
		aluResult: exMem.aluResult,
		loadData: dmemRdata,
		rdId: exMem.rdId
	};

	pipeReg #(.payloadT(memWbT)) memWbReg (
		.clk, .arstN,
		.en(1'b1),
		.flush(1'b0),
		.d(memWbD),
		.q(memWb)
	);

	// writeback
	assign wbValue = memWb.memToReg ? memWb.loadData : memWb.aluResult;
	assign hlt = memWb.isHalt; // HLTs keep following, so it stays up

endmodule

//--- verif/cpu_checker.sv
`timescale 1ns/10ps

module cpu_checker import cpuPkg::*; (
	input logic    clk,
	input logic    arstN,
	input dmemReqT dmemReq,
	input addrT    pc,
	input logic    hlt
);

	// one memory op per cycle
	reqOneHot: assert property (@(posedge clk) disable iff (!arstN)
		!(dmemReq.we && dmemReq.re))
		else $error("data request with write and read enable both high");

	haltSticky: assert property (@(posedge clk) disable iff (!arstN)
		hlt |=> hlt) // only reset clears it
		else $error("hlt dropped without a reset");

	noStoreHalted: assert property (@(posedge clk) disable iff (!arstN)
		hlt |-> !dmemReq.we)
		else $error("store issued while halted");

	pcParked: assert property (@(posedge clk) disable iff (!arstN)
		hlt |=> $stable(pc))
		else $error("pc moved while halted");

endmodule

bind cpu cpu_checker cpu_checker_i (
	.clk,
	.arstN,
	.dmemReq,
	.pc,
	.hlt
);

//--- verif/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb import cpuPkg::*; ();

	localparam int timeoutCycles = 2000; // cycle limit for one program

	logic clk = 1'b0;
	logic arstN = 1'b0;
	addrT imemAddr;
	wordT imemData;
	dmemReqT dmemReq;
	wordT dmemRdata;
	addrT pc;
	logic hlt;

	wordT patMem [0:1023]; // raw pattern words
	wordT imem [0:255];
	wordT dmem [0:32767];
	dmemReqT expStores [$];
	int storeIdx; // stores seen in the current test

	always #2 clk = ~clk; // 4 ns period

	cpu cpu_i (
		.clk,
		.arstN,
		.imemAddr,
		.imemData,
		.dmemReq,
		.dmemRdata,
		.pc,
		.hlt
	);

	// both memories answer in the same cycle
	assign imemData = imem[imemAddr[8:1]];
	assign dmemRdata = dmem[dmemReq.addr[15:1]];

	task automatic failNow(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic compareStore(input dmemReqT expected, input dmemReqT actual);
		if (actual !== expected) begin
			failNow($sformatf(
				"CHECK FAILED at %0t: store %0d expected %h/%h, got %h/%h we %b re %b",
				$time, storeIdx, expected.addr, expected.wdata,
				actual.addr, actual.wdata, actual.we, actual.re));
		end
	endtask

	task automatic comparePc(input string what, input addrT expected, input addrT actual);
		if (actual !== expected) begin
			failNow($sformatf("CHECK FAILED at %0t: halted %s expected %h, got %h",
				$time, what, expected, actual));
		end
	endtask

	// data memory refill while reset is held
	always @(posedge clk) begin
		if (!arstN) begin
			for (int i = 0; i < 32768; i++) begin
				dmem[i] = wordT'(i) ^ 16'hc3a5;
			end
		end else if (dmemReq.we) begin
			dmem[dmemReq.addr[15:1]] = dmemReq.wdata;
		end
	end

	// store monitor samples mid cycle
	always @(negedge clk) begin
		if (!arstN) begin
			storeIdx = 0;
		end else if (dmemReq.we) begin
			if (storeIdx >= expStores.size()) begin
				failNow($sformatf("an extra store to %h appeared after all expected stores",
					dmemReq.addr));
			end else begin
				compareStore(expStores[storeIdx], dmemReq);
				storeIdx++;
			end
		end
	end

	initial begin
		int idx;
		int nTests;
		int n;
		int cycles;
		dmemReqT req;
		addrT expPc;

		$readmemh("verif/cpu_patterns.txt", patMem);
		idx = 0;
		nTests = int'(patMem[idx]);
		idx++;
		for (int t = 0; t < nTests; t++) begin
			@(posedge clk);
			#1 arstN = 1'b0; // core held before the memories change
			n = int'(patMem[idx]);
			idx++;
			for (int i = 0; i < n; i++) begin
				imem[i] = patMem[idx];
				idx++;
			end
			expStores.delete();
			n = int'(patMem[idx]);
			idx++;
			for (int i = 0; i < n; i++) begin
				req.addr = patMem[idx];
				req.wdata = patMem[idx+1];
				req.we = 1'b1;
				req.re = 1'b0;
				expStores.push_back(req);
				idx += 2;
			end
			expPc = patMem[idx];
			idx++;

			repeat (3) @(posedge clk);
			#1 arstN = 1'b1;

			cycles = 0;
			while (!hlt && cycles < timeoutCycles) begin
				@(negedge clk);
				cycles++;
			end
			if (!hlt) begin
				failNow($sformatf("test %0d timed out, hlt never rose within %0d cycles",
					t, timeoutCycles));
			end
			comparePc("pc", expPc, pc);
			comparePc("imemAddr", expPc, imemAddr);
			if (storeIdx != expStores.size()) begin
				failNow($sformatf("test %0d halted after %0d of %0d expected stores",
					t, storeIdx, expStores.size()));
			end
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- compile.f
hw/cpuPkg.sv
hw/pipeReg.sv
hw/decodeCtrl.sv
hw/regFile.sv
hw/aluUnit.sv
hw/flagBranch.sv
hw/hazardFwd.sv
hw/cpu.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build the cpu testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert --top-module cpu_tb -o cpu_sim -f compile.f > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
simStatus=$?
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulator exited with status $simStatus"
	exit 1
fi
exit 0

//--- verif/cpu_patterns.txt
// test count, then per test: instr count, instr words, store count,
// store pairs (byte address, data), expected final pc (HLT address)
0004
// arithmetic, saturation, xor, shifts, rotate
001A
A1FF B17F A201 0312 9300 A400 B480 1542
9501 0622 9602 1721 9703 2814 9804 4914
9905 5A43 9A06 AC34 BC12 6BC4 9B07 0D44
9DCF F000
0009
0000 7FFF 0002 8000 0004 0002 0006 8002 0008 FFFF
000A FFF0 000C F000 000E 4123 1232 8000
0032
// forwarding chains and store data one and two back
000C
A105 0211 0321 1432 9400 2531 0655 9501 9662 A710 9370 F000
0004
0000 0005 0002 000A 0018 0014 0010 000F
0016
// load-use into add and into store
000D
A121 B143 9104 A201 8304 0432 9405 8504 9506 8605 1763 9707 F000
0004
0008 4321 000A 4322 000C 4321 000E 0001
0018
// every condition taken and not taken, counted loop, BR
003C
A101 A202 A3FF B37F AE00 BE01 AD10 BD01
AFEE 1921 C001 9FE0 C201 9FE1 C401 9FE2
C601 9FE3 CA01 9FE4 CC01 9FE5 C801 9FE6
1911 C201 9FE7 C001 9FD0 C401 9FD1 C801
9FD2 1912 C601 9FD3 CA01 9FD4 C401 9FD5
C801 9FD6 0933 CC01 9FD7 CE01 9F00 A403
A500 0552 1441 C1FD 9501 A670 DE60 9F02
9603 D060 9104 F000
000B
0102 00EE 0106 00EE 0108 00EE 010A 00EE 0110 00EE 0112 00EE
011A 00EE 011C 00EE 0002 0006 0006 0070 0008 0001
0076
